//--- Makefile
# Verilator build and run for the noc endpoint

VERILATOR ?= verilator
TOP       ?= tb_noc_endpoint
RTL_TOP   ?= noc_endpoint
FLIST     ?= noc_endpoint.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from the pass message in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- common/noc_consts.svh
// ***************************************************************************
// compile-time constants for the noc endpoint
// flit width, channel count, class field, class mapping, fifo depth
// ***************************************************************************

`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// flit and channel sizes
`define NOC_FLIT_WIDTH 32
`define NOC_CHANNELS 3

// class field sits in the top bits of a header flit
`define NOC_CLASS_MSB 31
`define NOC_CLASS_LSB 29

// one byte per class, low NOC_CHANNELS bits are the channel mask
// class 0 -> 001, class 1 -> 010, class 2 -> 100, classes 3..7 unmapped
// entries must be one-hot or zero, no multicast
`define NOC_CLASS_MAPPING 64'h0000_0000_0004_0201

// entries per flit fifo
`define NOC_BUF_DEPTH 4

`endif

//--- common/noc_pkg.sv
// ***************************************************************************
// shared types for the noc endpoint
// flit, channel mask and packet class
// ***************************************************************************

`include "noc_consts.svh"

package noc_pkg;

   // one flit on any link
   typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;

   // one bit per channel port
   typedef logic [`NOC_CHANNELS-1:0] chan_mask_t;

   // packet class from header flit bits 31..29
   typedef enum logic [2:0] {
      class_dma  = 3'd0,  // bulk transfers
      class_msg  = 3'd1,  // message passing
      class_sync = 3'd2,  // barriers, locks
      class_rsv3 = 3'd3,
      class_rsv4 = 3'd4,
      class_rsv5 = 3'd5,
      class_rsv6 = 3'd6,
      class_rsv7 = 3'd7
   } noc_class_e;

endpackage

//--- hdl/noc_buffer.sv
// ***************************************************************************
// synchronous flit fifo
// stores flit plus last marker, valid/ready on both sides
// ***************************************************************************

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_buffer (
   input  logic           clk,
   input  logic           rst,

   input  noc_pkg::flit_t in_flit,
   input  logic           in_last,
   input  logic           in_valid,
   output logic           in_ready,

   output noc_pkg::flit_t out_flit,
   output logic           out_last,
   output logic           out_valid,
   input  logic           out_ready
);
   import noc_pkg::*;

   localparam int DEPTH = `NOC_BUF_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);

   flit_t            mem_flit [DEPTH];
   logic [DEPTH-1:0] mem_last;
   logic [AW-1:0]    wr_ptr, rd_ptr;
   logic [CW-1:0]    count;           // occupancy
   logic             full, empty;
   logic             push, pop;

   // wrap at DEPTH, depth need not be a power of two
   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
      ptr_inc = (ptr == AW'(DEPTH-1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full  = (count == CW'(DEPTH));
   assign empty = (count == '0);

   assign in_ready  = ~full;   // accepts the cycle it becomes non-full
   assign out_valid = ~empty;
   assign out_flit  = mem_flit[rd_ptr];  // head of queue
   assign out_last  = mem_last[rd_ptr];

   assign push = in_valid & ~full;
   assign pop  = out_ready & ~empty;

   always_ff @(posedge clk) begin
      if (push) begin
         mem_flit[wr_ptr] <= in_flit;
         mem_last[wr_ptr] <= in_last;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // none or both
         endcase
      end
   end

endmodule

//--- hdl/noc_endpoint.sv
// ***************************************************************************
// noc endpoint top level
// ingress fifo into class demux, egress round-robin mux into fifo
// ***************************************************************************

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_endpoint (
   input  logic                                 clk,
   input  logic                                 rst,

   // from router
   input  noc_pkg::flit_t                       net_in_flit,
   input  logic                                 net_in_last,
   input  logic                                 net_in_valid,
   output logic                                 net_in_ready,

   // to channel sinks
   output noc_pkg::flit_t [`NOC_CHANNELS-1:0]   ch_out_flit,
   output noc_pkg::chan_mask_t                  ch_out_last,
   output noc_pkg::chan_mask_t                  ch_out_valid,
   input  noc_pkg::chan_mask_t                  ch_out_ready,

   // from channel sources
   input  noc_pkg::flit_t [`NOC_CHANNELS-1:0]   ch_in_flit,
   input  noc_pkg::chan_mask_t                  ch_in_last,
   input  noc_pkg::chan_mask_t                  ch_in_valid,
   output noc_pkg::chan_mask_t                  ch_in_ready,

   // to router
   output noc_pkg::flit_t                       net_out_flit,
   output logic                                 net_out_last,
   output logic                                 net_out_valid,
   input  logic                                 net_out_ready
);
   import noc_pkg::*;

   // fifo -> demux
   flit_t in_buf_flit;
   logic  in_buf_last, in_buf_valid, in_buf_ready;

   // mux -> fifo
   flit_t mux_flit;
   logic  mux_last, mux_valid, mux_ready;

   // ***********************************************************************
   // ingress
   // ***********************************************************************
   noc_buffer u_in_buffer (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (net_in_flit),
      .in_last   (net_in_last),
      .in_valid  (net_in_valid),
      .in_ready  (net_in_ready),
      .out_flit  (in_buf_flit),
      .out_last  (in_buf_last),
      .out_valid (in_buf_valid),
      .out_ready (in_buf_ready)
   );

   noc_demux u_demux (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_buf_flit),
      .in_last   (in_buf_last),
      .in_valid  (in_buf_valid),
      .in_ready  (in_buf_ready),
      .out_flit  (ch_out_flit),
      .out_last  (ch_out_last),
      .out_valid (ch_out_valid),
      .out_ready (ch_out_ready)
   );

   // ***********************************************************************
   // egress
   // ***********************************************************************
   noc_mux u_mux (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (ch_in_flit),
      .in_last   (ch_in_last),
      .in_valid  (ch_in_valid),
      .in_ready  (ch_in_ready),
      .out_flit  (mux_flit),
      .out_last  (mux_last),
      .out_valid (mux_valid),
      .out_ready (mux_ready)
   );

   noc_buffer u_out_buffer (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (mux_flit),
      .in_last   (mux_last),
      .in_valid  (mux_valid),
      .in_ready  (mux_ready),
      .out_flit  (net_out_flit),
      .out_last  (net_out_last),
      .out_valid (net_out_valid),
      .out_ready (net_out_ready)
   );

endmodule

//--- noc_demux/noc_demux.sv
// ***************************************************************************
// class demultiplexer
// steers whole packets to one channel by header class and mapping table
// ***************************************************************************

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_demux #(
   parameter logic [63:0] MAPPING = `NOC_CLASS_MAPPING  // 8 bits per class
) (
   input  logic                                 clk,
   input  logic                                 rst,

   input  noc_pkg::flit_t                       in_flit,
   input  logic                                 in_last,
   input  logic                                 in_valid,
   output logic                                 in_ready,

   output noc_pkg::flit_t [`NOC_CHANNELS-1:0]   out_flit,
   output noc_pkg::chan_mask_t                  out_last,
   output noc_pkg::chan_mask_t                  out_valid,
   input  noc_pkg::chan_mask_t                  out_ready
);
   import noc_pkg::*;

   noc_class_e packet_class;  // only meaningful on a header flit
   chan_mask_t select;        // channel looked up from class
   chan_mask_t route;         // channel used this cycle
   chan_mask_t active;        // held channel, zero while idle
   chan_mask_t active_nxt;
   logic       xfer;

   assign packet_class = noc_class_e'(in_flit[`NOC_CLASS_MSB:`NOC_CLASS_LSB]);

   // table lookup, unmapped classes fall back to channel 0
   always_comb begin
      select = MAPPING[8*packet_class +: `NOC_CHANNELS];
      if (select == '0) begin
         select = chan_mask_t'(1);
      end
   end

   // header picks the channel, body flits follow the held one
   assign route = (active == '0) ? select : active;

   // data fans out to all channels, only valid is steered
   assign out_flit  = {`NOC_CHANNELS{in_flit}};
   assign out_last  = {`NOC_CHANNELS{in_last}};
   assign out_valid = route & {`NOC_CHANNELS{in_valid}};
   assign in_ready  = |(route & out_ready);  // wait on selected channel only

   assign xfer = in_valid & in_ready;

   // ***********************************************************************
   // packet hold
   // ***********************************************************************
   always_comb begin
      active_nxt = active;
      if (active == '0) begin
         if (in_valid && !in_last) begin
            active_nxt = select;  // lock on multi-flit header
         end
      end else if (xfer && in_last) begin
         active_nxt = '0;         // packet done, back to idle
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active <= '0;
      end else begin
         active <= active_nxt;
      end
   end

endmodule

//--- noc_endpoint.f
+incdir+common
common/noc_pkg.sv
hdl/noc_buffer.sv
noc_demux/noc_demux.sv
noc_mux/noc_mux.sv
hdl/noc_endpoint.sv
tb/tb_noc_endpoint.sv

//--- noc_mux/noc_mux.sv
// ***************************************************************************
// packet-level round-robin multiplexer
// merges channel packets onto one link, packets never interleave
// ***************************************************************************

`timescale 1ns/1ns

`include "noc_consts.svh"

module noc_mux (
   input  logic                                 clk,
   input  logic                                 rst,

   input  noc_pkg::flit_t [`NOC_CHANNELS-1:0]   in_flit,
   input  noc_pkg::chan_mask_t                  in_last,
   input  noc_pkg::chan_mask_t                  in_valid,
   output noc_pkg::chan_mask_t                  in_ready,

   output noc_pkg::flit_t                       out_flit,
   output logic                                 out_last,
   output logic                                 out_valid,
   input  logic                                 out_ready
);
   import noc_pkg::*;

   localparam int PTR_W = (`NOC_CHANNELS > 1) ? $clog2(`NOC_CHANNELS) : 1;

   typedef enum logic {
      mux_idle,  // free to pick a new packet
      mux_busy   // mid-packet, grant locked
   } mux_state_e;

   mux_state_e       state, state_nxt;
   chan_mask_t       grant, grant_nxt;   // locked channel while busy
   logic [PTR_W-1:0] rr_ptr, rr_ptr_nxt; // first channel to look at
   chan_mask_t       pick;               // round-robin winner
   chan_mask_t       sel;                // channel forwarded this cycle
   logic [PTR_W-1:0] sel_idx;
   logic             xfer;

   // ***********************************************************************
   // round-robin search from rr_ptr
   // ***********************************************************************
   always_comb begin : rr_search
      int idx;
      pick = '0;
      for (int i = 0; i < `NOC_CHANNELS; i++) begin
         idx = (int'(rr_ptr) + i) % `NOC_CHANNELS;
         if (pick == '0 && in_valid[idx]) begin
            pick[idx] = 1'b1;  // first hit wins
         end
      end
   end

   assign sel = (state == mux_busy) ? grant : pick;

   // one-hot to index
   always_comb begin
      sel_idx = '0;
      for (int i = 0; i < `NOC_CHANNELS; i++) begin
         if (sel[i]) begin
            sel_idx = PTR_W'(i);
         end
      end
   end

   assign out_flit  = in_flit[sel_idx];
   assign out_last  = |(in_last & sel);
   assign out_valid = |(in_valid & sel);
   assign in_ready  = sel & {`NOC_CHANNELS{out_ready}};

   assign xfer = out_valid & out_ready;

   // ***********************************************************************
   // grant and pointer update
   // ***********************************************************************
   always_comb begin
      state_nxt  = state;
      grant_nxt  = grant;
      rr_ptr_nxt = rr_ptr;
      if (xfer) begin
         if (out_last) begin
            state_nxt  = mux_idle;
            grant_nxt  = '0;
            // next search starts after the channel just served
            rr_ptr_nxt = (sel_idx == PTR_W'(`NOC_CHANNELS-1)) ? '0 : sel_idx + 1'b1;
         end else begin
            state_nxt = mux_busy;  // hold until last flit
            grant_nxt = sel;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= mux_idle;
         grant  <= '0;
         rr_ptr <= '0;
      end else begin
         state  <= state_nxt;
         grant  <= grant_nxt;
         rr_ptr <= rr_ptr_nxt;
      end
   end

endmodule

//--- tb/tb_noc_endpoint.sv
// ***************************************************************************
// testbench for the noc endpoint
// clock, reset, ingress and egress stimulus, class reference model,
// scoreboard queues, compare tasks and result reporting
// ***************************************************************************

`timescale 1ns/1ns

`include "noc_consts.svh"

module tb_noc_endpoint;
   import noc_pkg::*;

   localparam int HANDSHAKE_LIMIT = 500;   // cycles per flit
   localparam int DRAIN_LIMIT     = 2000;  // cycles per test drain

   logic                               clk;
   logic                               rst;
   flit_t                              net_in_flit;
   logic                               net_in_last, net_in_valid, net_in_ready;
   flit_t [`NOC_CHANNELS-1:0]          ch_out_flit;
   chan_mask_t                         ch_out_last, ch_out_valid, ch_out_ready;
   flit_t [`NOC_CHANNELS-1:0]          ch_in_flit;
   chan_mask_t                         ch_in_last, ch_in_valid, ch_in_ready;
   flit_t                              net_out_flit;
   logic                               net_out_last, net_out_valid, net_out_ready;

   integer     seed = 32'h3d84_7b07;
   int         errors, checks, tests;
   logic       rand_ch_ready, rand_net_ready;  // back-pressure enables
   logic       rot_check;                      // egress rotation check on
   int         next_src, egress_src;
   logic       egress_in_pkt;
   logic [35:0] ch_exp_q  [`NOC_CHANNELS][$];  // {mask, last, flit}
   logic [32:0] src_exp_q [`NOC_CHANNELS][$];  // {last, flit}
   logic [35:0] ch_entry;
   logic [32:0] src_entry;

   noc_endpoint u_noc_endpoint (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   // ***********************************************************************
   // reference model and compare tasks
   // ***********************************************************************
   function automatic int expected_channel(flit_t hdr);
      logic [2:0] cls;
      logic [7:0] entry;
      int         ch;
      cls   = hdr[`NOC_CLASS_MSB:`NOC_CLASS_LSB];
      entry = 8'(64'(`NOC_CLASS_MAPPING) >> (8 * cls));
      ch    = 0;  // unmapped class goes to channel 0
      for (int c = `NOC_CHANNELS - 1; c >= 0; c--) begin
         if (entry[c]) ch = c;
      end
      return ch;
   endfunction

   function automatic flit_t make_header(noc_class_e cls, logic [28:0] body);
      return {cls, body};
   endfunction

   task automatic check_flit(flit_t got, flit_t exp, string what);
      checks++;
      if (got !== exp) begin
         $display("FAILED at %0t: %s flit %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_last(logic got, logic exp, string what);
      checks++;
      if (got !== exp) begin
         $display("FAILED at %0t: %s last %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_channel(chan_mask_t got, chan_mask_t exp, string what);
      checks++;
      if (got !== exp) begin
         $display("FAILED at %0t: %s mask %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_level(logic got, logic exp, string what);
      checks++;
      if (got !== exp) begin
         $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   // ***********************************************************************
   // ending the run
   // ***********************************************************************
   task automatic report_and_finish();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   task automatic abort_on_timeout(string what);
      $display("timed out at %0t while waiting: %s", $time, what);
      errors++;
      report_and_finish();
   endtask

   task automatic end_test(string name, int errors_before);
      tests++;
      $display("test %0d %s finished, %0d errors", tests, name, errors - errors_before);
   endtask

   // ***********************************************************************
   // drivers, all on the falling edge
   // ***********************************************************************
   task automatic send_net_flit(flit_t flit, logic last);
      int   cycles;
      logic taken;
      @(negedge clk);
      net_in_flit  = flit;
      net_in_last  = last;
      net_in_valid = 1'b1;
      cycles = 0;
      taken  = 1'b0;
      while (!taken && cycles < HANDSHAKE_LIMIT) begin
         @(posedge clk);
         taken = net_in_ready;  // pre-edge value decides the transfer
         cycles++;
      end
      if (!taken) abort_on_timeout("network flit never accepted at net_in");
   endtask

   task automatic send_net_packet(flit_t hdr, int len);
      int         ch;
      chan_mask_t mask;
      flit_t      flit;
      logic       last;
      ch   = expected_channel(hdr);
      mask = chan_mask_t'(1 << ch);
      for (int i = 0; i < len; i++) begin
         flit = (i == 0) ? hdr : flit_t'($random(seed));  // body class bits random
         last = (i == len - 1);
         ch_exp_q[ch].push_back({mask, last, flit});
         send_net_flit(flit, last);
      end
   endtask

   task automatic send_src_flit(int s, flit_t flit, logic last);
      int   cycles;
      logic taken;
      @(negedge clk);
      ch_in_flit[s]  = flit;
      ch_in_last[s]  = last;
      ch_in_valid[s] = 1'b1;
      cycles = 0;
      taken  = 1'b0;
      while (!taken && cycles < HANDSHAKE_LIMIT) begin
         @(posedge clk);
         taken = ch_in_ready[s];
         cycles++;
      end
      if (!taken) abort_on_timeout($sformatf("source %0d flit never accepted", s));
   endtask

   task automatic drive_source(int s, int npkt);
      int    len;
      flit_t flit;
      logic  last;
      for (int p = 0; p < npkt; p++) begin
         len = 1 + ($unsigned($random(seed)) % 4);
         for (int i = 0; i < len; i++) begin
            // source id in bits 25:24, then packet and flit index
            flit = {6'd0, 2'(s), 8'(p), 8'(i), 8'($random(seed))};
            last = (i == len - 1);
            src_exp_q[s].push_back({last, flit});
            send_src_flit(s, flit, last);
         end
      end
      @(negedge clk);
      ch_in_valid[s] = 1'b0;
   endtask

   function automatic int pending();
      int n;
      n = 0;
      for (int c = 0; c < `NOC_CHANNELS; c++) begin
         n += ch_exp_q[c].size() + src_exp_q[c].size();
      end
      return n;
   endfunction

   task automatic wait_drained(string what);
      int cycles;
      cycles = 0;
      while (pending() != 0 && cycles < DRAIN_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (pending() != 0) abort_on_timeout(what);
   endtask

   // random ready levels for the sinks and the router
   always @(negedge clk) begin
      ch_out_ready  = rand_ch_ready  ? chan_mask_t'($random(seed)) : '1;
      net_out_ready = rand_net_ready ? 1'($random(seed))           : 1'b1;
   end

   // ***********************************************************************
   // monitors
   // ***********************************************************************
   always @(posedge clk) begin : ingress_monitor
      if (!rst) begin
         for (int c = 0; c < `NOC_CHANNELS; c++) begin
            if (ch_out_valid[c] && ch_out_ready[c]) begin
               if (ch_exp_q[c].size() == 0) begin
                  $display("channel %0d delivered an unexpected flit at %0t", c, $time);
                  errors++;
               end else begin
                  ch_entry = ch_exp_q[c].pop_front();
                  check_channel(ch_out_valid, ch_entry[35:33], "ingress channel");
                  check_flit(ch_out_flit[c], ch_entry[31:0], "ingress");
                  check_last(ch_out_last[c], ch_entry[32], "ingress");
               end
            end
         end
      end
   end

   always @(posedge clk) begin : egress_monitor
      if (!rst && net_out_valid && net_out_ready) begin
         if (!egress_in_pkt) begin
            egress_src = int'(net_out_flit[25:24]);  // source of a new packet
            if (rot_check) begin
               check_channel(chan_mask_t'(1 << egress_src), chan_mask_t'(1 << next_src),
                             "egress rotation");
               next_src = (egress_src + 1) % `NOC_CHANNELS;
            end
         end
         if (egress_src >= `NOC_CHANNELS || src_exp_q[egress_src].size() == 0) begin
            $display("net_out delivered a flit no source sent at %0t", $time);
            errors++;
         end else begin
            src_entry = src_exp_q[egress_src].pop_front();  // interleave shows as mismatch
            check_flit(net_out_flit, src_entry[31:0], "egress");
            check_last(net_out_last, src_entry[32], "egress");
         end
         egress_in_pkt = !net_out_last;
      end
   end

   // ***********************************************************************
   // test sequence
   // ***********************************************************************
   initial begin
      int e0;
      rst            = 1'b1;
      net_in_flit    = '0;
      net_in_last    = 1'b0;
      net_in_valid   = 1'b0;
      ch_out_ready   = '1;
      ch_in_flit     = '0;
      ch_in_last     = '0;
      ch_in_valid    = '0;
      net_out_ready  = 1'b1;
      rand_ch_ready  = 1'b0;
      rand_net_ready = 1'b0;
      rot_check      = 1'b0;
      next_src       = 0;
      egress_src     = 0;
      egress_in_pkt  = 1'b0;
      errors         = 0;
      checks         = 0;
      tests          = 0;

      // reset state during and after reset
      e0 = errors;
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_level(net_in_ready, 1'b1, "net_in_ready in reset");
      check_channel(ch_out_valid, '0, "ch_out_valid in reset");
      check_level(net_out_valid, 1'b0, "net_out_valid in reset");
      @(posedge clk);
      @(negedge clk);
      rst = 1'b0;  // four rising edges seen in reset
      @(negedge clk);
      check_level(net_in_ready, 1'b1, "net_in_ready after reset");
      check_channel(ch_out_valid, '0, "ch_out_valid after reset");
      check_level(net_out_valid, 1'b0, "net_out_valid after reset");
      end_test("reset", e0);

      // one single-flit packet per class
      e0 = errors;
      for (int k = 0; k < 8; k++) begin
         send_net_packet(make_header(noc_class_e'(k), 29'(k)), 1);
      end
      @(negedge clk);
      net_in_valid = 1'b0;
      wait_drained("class routing packets to drain");
      end_test("class routing", e0);

      // multi-flit packets with random class bits in the body
      e0 = errors;
      for (int k = 0; k < 12; k++) begin
         send_net_packet(make_header(noc_class_e'($random(seed)), 29'($random(seed))),
                         2 + ($unsigned($random(seed)) % 4));
      end
      @(negedge clk);
      net_in_valid = 1'b0;
      wait_drained("held packets to drain");
      end_test("packet hold", e0);

      // random packets with random sink ready
      e0 = errors;
      rand_ch_ready = 1'b1;
      for (int k = 0; k < 24; k++) begin
         send_net_packet(make_header(noc_class_e'($random(seed)), 29'($random(seed))),
                         1 + ($unsigned($random(seed)) % 4));
      end
      @(negedge clk);
      net_in_valid = 1'b0;
      wait_drained("back-pressured packets to drain");
      rand_ch_ready = 1'b0;
      end_test("ingress back-pressure", e0);

      // three busy sources against a random router ready
      e0 = errors;
      rand_net_ready = 1'b1;
      rot_check      = 1'b1;  // mux pointer still at channel 0
      fork
         drive_source(0, 6);
         drive_source(1, 6);
         drive_source(2, 6);
      join
      wait_drained("egress packets to drain");
      rand_net_ready = 1'b0;
      rot_check      = 1'b0;
      end_test("egress merge", e0);

      report_and_finish();
   end

endmodule
